// File: Bender.yml
package:
  name: legv8_pipeline

sources:
  - legv8_isa_pkg.sv
  - pipeline_pkg.sv
  - stage_register.sv
  - fetch_unit.sv
  - instruction_decoder.sv
  - register_file.sv
  - hazard_unit.sv
  - execute_stage.sv
  - legv8_pipeline.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_legv8_pipeline.sv

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire pipeline_pkg::decode_payload_t  payload,
  input  wire pipeline_pkg::forward_sel_t     forward_rn,
  input  wire pipeline_pkg::forward_sel_t     forward_rm,
  input  wire pipeline_pkg::word_t            memory_result,
  input  wire pipeline_pkg::word_t            writeback_result,
  output pipeline_pkg::execute_payload_t      result
);

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  word_t operand_a;
  word_t rm_value;
  word_t operand_b;
  word_t alu_result;

  function automatic word_t forward_mux(input forward_sel_t sel, input word_t own);
    case (sel)
      FWD_MEMORY:    return memory_result;
      FWD_WRITEBACK: return writeback_result;
      default:       return own;
    endcase
  endfunction

  always_comb begin
    operand_a = forward_mux(forward_rn, payload.rn_data);
    rm_value  = forward_mux(forward_rm, payload.rm_data);
    operand_b = payload.use_immediate ? payload.immediate : rm_value;  // Address offset
  end

  always_comb begin
    case (payload.alu_op)
      ALU_AND: alu_result = operand_a & operand_b;
      ALU_ORR: alu_result = operand_a | operand_b;
      ALU_ADD: alu_result = operand_a + operand_b;
      ALU_SUB: alu_result = operand_a - operand_b;
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    result.reg_write  = payload.reg_write;
    result.mem_read   = payload.mem_read;
    result.mem_write  = payload.mem_write;
    result.mem_to_reg = payload.mem_to_reg;
    result.alu_result = alu_result;
    result.store_data = rm_value;  // Rt for STUR
    result.rd         = payload.rd;
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter pipeline_pkg::word_t RESET_PC = '0
) (
  input  wire                 CLOCK,
  input  wire                 reset,
  input  wire                 stall,
  input  wire [31:0]          instruction,
  output pipeline_pkg::word_t instruction_address,
  output pipeline_pkg::word_t fetched_pc,
  output logic [31:0]         fetched_instruction
);

  import pipeline_pkg::*;

  localparam logic [31:0] NOP_INSTRUCTION = 32'h0000_0000;  // Opcode zero is not supported

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      instruction_address <= RESET_PC;
    end else if (!stall) begin
      instruction_address <= instruction_address + word_t'(4);
    end
  end

  // Fetch/decode register
  always_ff @(posedge CLOCK) begin
    if (reset) begin
      fetched_pc          <= RESET_PC;
      fetched_instruction <= NOP_INSTRUCTION;
    end else if (!stall) begin  // Hold during load-use
      fetched_pc          <= instruction_address;
      fetched_instruction <= instruction;
    end
  end

  a_pc_aligned: assert property (@(posedge CLOCK) disable iff (reset)
    instruction_address[1:0] == 2'b00)
    else $error("PC lost word alignment");

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
legv8_isa_pkg.sv
pipeline_pkg.sv
stage_register.sv
fetch_unit.sv
instruction_decoder.sv
register_file.sv
hazard_unit.sv
execute_stage.sv
legv8_pipeline.sv
tb_legv8_pipeline.sv

// File: hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire                             CLOCK,
  input  wire                             reset,
  input  wire legv8_isa_pkg::reg_index_t  rn,
  input  wire legv8_isa_pkg::reg_index_t  rm,
  input  wire                             execute_mem_read,
  input  wire legv8_isa_pkg::reg_index_t  execute_rd,
  input  wire legv8_isa_pkg::reg_index_t  ex_rn,
  input  wire legv8_isa_pkg::reg_index_t  ex_rm,
  input  wire                             memory_reg_write,
  input  wire legv8_isa_pkg::reg_index_t  memory_rd,
  input  wire                             writeback_reg_write,
  input  wire legv8_isa_pkg::reg_index_t  writeback_rd,
  output logic                            stall,
  output pipeline_pkg::forward_sel_t      forward_rn,
  output pipeline_pkg::forward_sel_t      forward_rm
);

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  // Younger result wins
  function automatic forward_sel_t select_source(input reg_index_t source);
    if (memory_reg_write && memory_rd != ZERO_REG && memory_rd == source) begin
      return FWD_MEMORY;
    end
    if (writeback_reg_write && writeback_rd != ZERO_REG && writeback_rd == source) begin
      return FWD_WRITEBACK;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    forward_rn = select_source(ex_rn);
    forward_rm = select_source(ex_rm);
  end

  assign stall = execute_mem_read && execute_rd != ZERO_REG &&
                 (execute_rd == rn || execute_rd == rm);

  // The killed slot behind a load must clear the hazard
  a_single_stall: assert property (@(posedge CLOCK) disable iff (reset) stall |=> !stall)
    else $error("Load-use stall lasted more than one cycle");

endmodule

`default_nettype wire

// File: instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
  input  wire [31:0]                   fetched_instruction,
  input  wire                          kill,
  input  wire pipeline_pkg::word_t     rn_data,
  input  wire pipeline_pkg::word_t     rm_data,
  output legv8_isa_pkg::reg_index_t    rn,
  output legv8_isa_pkg::reg_index_t    rm,
  output pipeline_pkg::decode_payload_t payload
);

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  opcode_t    opcode;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       mem_to_reg;
  logic       use_immediate;
  alu_op_t    alu_op;
  word_t      offset;
  reg_index_t rd;

  assign opcode = fetched_instruction[31:21];

  always_comb begin
    reg_write     = 1'b0;
    mem_read      = 1'b0;
    mem_write     = 1'b0;
    mem_to_reg    = 1'b0;
    use_immediate = 1'b0;
    alu_op        = ALU_ADD;
    offset        = '0;
    rn            = ZERO_REG;  // Unused sources never match a hazard
    rm            = ZERO_REG;
    rd            = ZERO_REG;
    case (opcode)
      OPCODE_LDUR: begin
        reg_write     = 1'b1;
        mem_read      = 1'b1;
        mem_to_reg    = 1'b1;
        use_immediate = 1'b1;
        offset        = {{(DATA_WIDTH-OFFSET_WIDTH){fetched_instruction[20]}},
                         fetched_instruction[20:12]};
        rn            = fetched_instruction[9:5];
        rd            = fetched_instruction[4:0];
      end
      OPCODE_STUR: begin
        mem_write     = 1'b1;
        use_immediate = 1'b1;
        offset        = {{(DATA_WIDTH-OFFSET_WIDTH){fetched_instruction[20]}},
                         fetched_instruction[20:12]};
        rn            = fetched_instruction[9:5];
        rm            = fetched_instruction[4:0];  // Rt holds the store data
      end
      OPCODE_ADD, OPCODE_SUB, OPCODE_AND, OPCODE_ORR: begin
        reg_write = 1'b1;
        rn        = fetched_instruction[9:5];
        rm        = fetched_instruction[20:16];
        rd        = fetched_instruction[4:0];
        case (opcode)
          OPCODE_SUB: alu_op = ALU_SUB;
          OPCODE_AND: alu_op = ALU_AND;
          OPCODE_ORR: alu_op = ALU_ORR;
          default:    alu_op = ALU_ADD;
        endcase
      end
      default: ;  // No-op
    endcase
  end

  always_comb begin
    payload.reg_write     = reg_write && !kill;  // Bubble on stall
    payload.mem_read      = mem_read && !kill;
    payload.mem_write     = mem_write && !kill;
    payload.mem_to_reg    = mem_to_reg;
    payload.use_immediate = use_immediate;
    payload.alu_op        = alu_op;
    payload.rn_data       = rn_data;
    payload.rm_data       = rm_data;
    payload.immediate     = offset;
    payload.rd            = rd;
    payload.rn            = rn;
    payload.rm            = rm;
  end

endmodule

`default_nettype wire

// File: legv8_isa_pkg.sv
`default_nettype none

package legv8_isa_pkg;

  localparam int NUM_REGS = 32;
  localparam int OFFSET_WIDTH = 9;  // D-format address offset

  typedef logic [4:0] reg_index_t;

  localparam reg_index_t ZERO_REG = 5'd31;  // XZR

  typedef logic [10:0] opcode_t;

  localparam opcode_t OPCODE_LDUR = 11'b11111000010;
  localparam opcode_t OPCODE_STUR = 11'b11111000000;
  localparam opcode_t OPCODE_ADD  = 11'b10001011000;
  localparam opcode_t OPCODE_SUB  = 11'b11001011000;
  localparam opcode_t OPCODE_AND  = 11'b10001010000;
  localparam opcode_t OPCODE_ORR  = 11'b10101010000;

  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_ORR = 4'b0001,
    ALU_ADD = 4'b0010,
    ALU_SUB = 4'b0110
  } alu_op_t;

endpackage

`default_nettype wire

// File: legv8_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module legv8_pipeline #(
  parameter pipeline_pkg::word_t RESET_PC = '0
) (
  input  wire                      CLOCK,
  input  wire                      reset,
  input  wire [31:0]               instruction,
  input  wire pipeline_pkg::word_t mem_read_data,
  output pipeline_pkg::word_t      instruction_address,
  output pipeline_pkg::word_t      mem_address,
  output pipeline_pkg::word_t      mem_write_data,
  output logic                     mem_read,
  output logic                     mem_write
);

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  word_t            fetched_pc;
  logic [31:0]      fetched_instruction;
  logic             stall;
  reg_index_t       rn;
  reg_index_t       rm;
  word_t            rn_data;
  word_t            rm_data;
  decode_payload_t  decoded;
  decode_payload_t  id_ex;
  forward_sel_t     forward_rn;
  forward_sel_t     forward_rm;
  execute_payload_t executed;
  execute_payload_t ex_mem;
  memory_payload_t  memory_out;
  memory_payload_t  mem_wb;
  word_t            writeback_value;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) i_fetch_unit (
    .CLOCK               (CLOCK),
    .reset               (reset),
    .stall               (stall),
    .instruction         (instruction),
    .instruction_address (instruction_address),
    .fetched_pc          (fetched_pc),
    .fetched_instruction (fetched_instruction)
  );

  instruction_decoder i_instruction_decoder (
    .fetched_instruction (fetched_instruction),
    .kill                (stall),
    .rn_data             (rn_data),
    .rm_data             (rm_data),
    .rn                  (rn),
    .rm                  (rm),
    .payload             (decoded)
  );

  register_file i_register_file (
    .CLOCK        (CLOCK),
    .reset        (reset),
    .rn           (rn),
    .rm           (rm),
    .write_enable (mem_wb.reg_write),
    .write_index  (mem_wb.rd),
    .write_data   (writeback_value),
    .rn_data      (rn_data),
    .rm_data      (rm_data)
  );

  hazard_unit i_hazard_unit (
    .CLOCK               (CLOCK),
    .reset               (reset),
    .rn                  (rn),
    .rm                  (rm),
    .execute_mem_read    (id_ex.mem_read),
    .execute_rd          (id_ex.rd),
    .ex_rn               (id_ex.rn),
    .ex_rm               (id_ex.rm),
    .memory_reg_write    (ex_mem.reg_write),
    .memory_rd           (ex_mem.rd),
    .writeback_reg_write (mem_wb.reg_write),
    .writeback_rd        (mem_wb.rd),
    .stall               (stall),
    .forward_rn          (forward_rn),
    .forward_rm          (forward_rm)
  );

  stage_register #(.payload_t(decode_payload_t)) i_id_ex (
    .CLOCK (CLOCK),
    .reset (reset),
    .d     (decoded),
    .q     (id_ex)
  );

  execute_stage i_execute_stage (
    .payload          (id_ex),
    .forward_rn       (forward_rn),
    .forward_rm       (forward_rm),
    .memory_result    (ex_mem.alu_result),
    .writeback_result (writeback_value),
    .result           (executed)
  );

  stage_register #(.payload_t(execute_payload_t)) i_ex_mem (
    .CLOCK (CLOCK),
    .reset (reset),
    .d     (executed),
    .q     (ex_mem)
  );

  assign mem_address    = ex_mem.alu_result;
  assign mem_write_data = ex_mem.store_data;
  assign mem_read       = ex_mem.mem_read;
  assign mem_write      = ex_mem.mem_write;

  always_comb begin
    memory_out.reg_write  = ex_mem.reg_write;
    memory_out.mem_to_reg = ex_mem.mem_to_reg;
    memory_out.alu_result = ex_mem.alu_result;
    memory_out.load_data  = ex_mem.mem_read ? mem_read_data : '0;  // Bus idle otherwise
    memory_out.rd         = ex_mem.rd;
  end

  stage_register #(.payload_t(memory_payload_t)) i_mem_wb (
    .CLOCK (CLOCK),
    .reset (reset),
    .d     (memory_out),
    .q     (mem_wb)
  );

  assign writeback_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

  // A stall freezes fetch and leaves a bubble in ID/EX
  a_stall_bubble: assert property (@(posedge CLOCK) disable iff (reset)
    stall |=> $stable(fetched_pc) && !id_ex.reg_write && !id_ex.mem_read && !id_ex.mem_write)
    else $error("Stall did not hold fetch or insert a bubble");

endmodule

`default_nettype wire

// File: pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

  localparam int DATA_WIDTH = 64;

  typedef logic [DATA_WIDTH-1:0] word_t;

  typedef enum logic [1:0] {
    FWD_NONE      = 2'b00,
    FWD_WRITEBACK = 2'b01,
    FWD_MEMORY    = 2'b10
  } forward_sel_t;

  // ID/EX
  typedef struct packed {
    logic                       reg_write;
    logic                       mem_read;
    logic                       mem_write;
    logic                       mem_to_reg;
    logic                       use_immediate;
    legv8_isa_pkg::alu_op_t     alu_op;
    word_t                      rn_data;
    word_t                      rm_data;
    word_t                      immediate;
    legv8_isa_pkg::reg_index_t  rd;
    legv8_isa_pkg::reg_index_t  rn;
    legv8_isa_pkg::reg_index_t  rm;
  } decode_payload_t;

  // EX/MEM
  typedef struct packed {
    logic                       reg_write;
    logic                       mem_read;
    logic                       mem_write;
    logic                       mem_to_reg;
    word_t                      alu_result;
    word_t                      store_data;
    legv8_isa_pkg::reg_index_t  rd;
  } execute_payload_t;

  // MEM/WB
  typedef struct packed {
    logic                       reg_write;
    logic                       mem_to_reg;
    word_t                      alu_result;
    word_t                      load_data;
    legv8_isa_pkg::reg_index_t  rd;
  } memory_payload_t;

endpackage

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                             CLOCK,
  input  wire                             reset,
  input  wire legv8_isa_pkg::reg_index_t  rn,
  input  wire legv8_isa_pkg::reg_index_t  rm,
  input  wire                             write_enable,
  input  wire legv8_isa_pkg::reg_index_t  write_index,
  input  wire pipeline_pkg::word_t        write_data,
  output pipeline_pkg::word_t             rn_data,
  output pipeline_pkg::word_t             rm_data
);

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= word_t'(i);  // Xi starts as i
      end
    end else if (write_enable && write_index != ZERO_REG) begin
      regs[write_index] <= write_data;
    end
  end

  function automatic word_t read_port(input reg_index_t index);
    if (index == ZERO_REG) begin
      return '0;
    end
    if (write_enable && write_index == index) begin
      return write_data;  // Writeback bypass
    end
    return regs[index];
  endfunction

  always_comb begin
    rn_data = read_port(rn);
    rm_data = read_port(rm);
  end

endmodule

`default_nettype wire

// File: stage_register.sv
`timescale 1ns/1ps
`default_nettype none

module stage_register #(
  parameter type payload_t = logic
) (
  input  wire           CLOCK,
  input  wire           reset,
  input  wire payload_t d,
  output payload_t      q
);

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      q <= '0;  // Idle payload with all controls low
    end else begin
      q <= d;
    end
  end

  // Known payload relies on decoder defaults and gated load data upstream
  a_payload_known: assert property (@(posedge CLOCK) disable iff (reset) !$isunknown(q))
    else $error("Stage register carries unknown bits");

endmodule

`default_nettype wire

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int MAX_PROGRAM = 512;
localparam int MAX_STORES  = 256;
localparam int MAX_LOADS   = 256;

int unsigned lcg_state = 36;
word_t       model_regs [32];
word_t       model_mem [32];
word_t       expected_address [MAX_STORES];
word_t       expected_data [MAX_STORES];
int          expected_stores = 0;
word_t       expected_load_address [MAX_LOADS];
int          expected_loads = 0;
logic [31:0] program_mem [MAX_PROGRAM];
int          program_length = 0;

function automatic int unsigned next_random();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state >> 16;  // Low bits of an LCG cycle too fast
endfunction

function automatic logic [31:0] r_format(input opcode_t opcode, input reg_index_t rd,
                                         input reg_index_t rn, input reg_index_t rm);
  return {opcode, rm, 6'd0, rn, rd};
endfunction

function automatic logic [31:0] d_format(input opcode_t opcode, input reg_index_t rt,
                                         input reg_index_t rn, input logic [8:0] offset);
  return {opcode, offset, 2'b00, rn, rt};
endfunction

function automatic word_t read_model(input reg_index_t index);
  return (index == ZERO_REG) ? '0 : model_regs[index];
endfunction

function automatic word_t offset_address(input reg_index_t rn, input logic [8:0] offset);
  return read_model(rn) + {{(DATA_WIDTH-9){offset[8]}}, offset};
endfunction

task automatic reset_model();
  int i;
  for (i = 0; i < 32; i++) begin
    model_regs[i] = word_t'(i);
    model_mem[i]  = word_t'(i * 5);
  end
  expected_stores = 0;
  expected_loads  = 0;
  program_length  = 0;
endtask

// Each call appends one instruction and runs it on the model
task automatic alu_instr(input opcode_t opcode, input reg_index_t rd,
                         input reg_index_t rn, input reg_index_t rm);
  word_t a;
  word_t b;
  word_t value;
  a = read_model(rn);
  b = read_model(rm);
  case (opcode)
    OPCODE_SUB: value = a - b;
    OPCODE_AND: value = a & b;
    OPCODE_ORR: value = a | b;
    default:    value = a + b;
  endcase
  program_mem[program_length] = r_format(opcode, rd, rn, rm);
  program_length++;
  if (rd != ZERO_REG) model_regs[rd] = value;
endtask

task automatic load_instr(input reg_index_t rt, input reg_index_t rn, input logic [8:0] offset);
  word_t address;
  address = offset_address(rn, offset);
  program_mem[program_length] = d_format(OPCODE_LDUR, rt, rn, offset);
  program_length++;
  expected_load_address[expected_loads] = address;
  expected_loads++;
  if (rt != ZERO_REG) model_regs[rt] = model_mem[address[4:0]];  // 32-word memory
endtask

task automatic store_instr(input reg_index_t rt, input reg_index_t rn, input logic [8:0] offset);
  word_t address;
  word_t data;
  address = offset_address(rn, offset);
  data    = read_model(rt);
  program_mem[program_length] = d_format(OPCODE_STUR, rt, rn, offset);
  program_length++;
  expected_address[expected_stores] = address;
  expected_data[expected_stores]    = data;
  expected_stores++;
  model_mem[address[4:0]] = data;
endtask

`endif

// File: tb_legv8_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_legv8_pipeline;

  import legv8_isa_pkg::*;
  import pipeline_pkg::*;

  localparam word_t RESET_PC     = 64'h100;
  localparam int    RESET_CYCLES = 16;

  logic        CLOCK;
  logic        reset;
  logic [31:0] instruction;
  word_t       mem_read_data;
  word_t       instruction_address;
  word_t       mem_address;
  word_t       mem_write_data;
  logic        mem_read;
  logic        mem_write;

  word_t data_mem [32];
  word_t fetch_slot;
  word_t next_address;
  word_t next_data;
  word_t next_load_address;
  word_t previous_address = '0;
  logic  reset_q = 1'b0;  // Reset as seen at the previous edge
  int    errors = 0;
  int    store_count = 0;
  int    load_count = 0;
  int    checked_stores = 0;
  int    hold_count = 0;
  int    hold_run = 0;

  `include "tb_model.svh"

  legv8_pipeline #(
    .RESET_PC (RESET_PC)
  ) i_legv8_pipeline (
    .CLOCK               (CLOCK),
    .reset               (reset),
    .instruction         (instruction),
    .mem_read_data       (mem_read_data),
    .instruction_address (instruction_address),
    .mem_address         (mem_address),
    .mem_write_data      (mem_write_data),
    .mem_read            (mem_read),
    .mem_write           (mem_write)
  );

  initial begin
    CLOCK = 1'b0;
    forever #10 CLOCK = ~CLOCK;
  end

  // No-op past the end of the program
  assign fetch_slot        = (instruction_address - RESET_PC) >> 2;
  assign instruction       = (fetch_slot < program_length) ? program_mem[fetch_slot] : 32'h0;
  assign mem_read_data     = data_mem[mem_address[4:0]];
  assign next_address      = expected_address[store_count];
  assign next_data         = expected_data[store_count];
  assign next_load_address = expected_load_address[load_count];

  always @(posedge CLOCK) begin
    if (mem_write) data_mem[mem_address[4:0]] <= mem_write_data;
    if (!reset && mem_write) store_count <= store_count + 1;
    if (!reset && mem_read) load_count <= load_count + 1;
  end

  // Counts cycles where the PC repeats
  always @(posedge CLOCK) begin
    reset_q          <= reset;
    previous_address <= instruction_address;
    if (reset || reset_q || instruction_address != previous_address) begin
      hold_run <= 0;
    end else begin
      hold_run   <= hold_run + 1;
      hold_count <= hold_count + 1;
    end
  end

  a_reset_idle: assert property (@(posedge CLOCK)
    reset_q |-> !mem_read && !mem_write && instruction_address == RESET_PC)
    else begin
      errors++;
      $display("FAILED at %0t: outputs not idle around reset", $time);
    end

  a_store_match: assert property (@(posedge CLOCK) disable iff (reset)
    mem_write |-> store_count < expected_stores && mem_address == next_address &&
                  mem_write_data == next_data)
    else begin
      errors++;
      $display("FAILED at %0t: store %0d got %h <- %h, expected %h <- %h", $time,
               $sampled(store_count), $sampled(mem_address), $sampled(mem_write_data),
               $sampled(next_address), $sampled(next_data));
    end

  a_load_match: assert property (@(posedge CLOCK) disable iff (reset)
    mem_read |-> !mem_write && load_count < expected_loads &&
                 mem_address == next_load_address)
    else begin
      errors++;
      $display("FAILED at %0t: load %0d read %h, expected %h", $time,
               $sampled(load_count), $sampled(mem_address), $sampled(next_load_address));
    end

  a_hold_short: assert property (@(posedge CLOCK) hold_run <= 1)
    else begin
      errors++;
      $display("FAILED at %0t: PC %h held longer than two cycles", $time,
               $sampled(instruction_address));
    end

  task automatic report_counts();
    $display("Stores checked: %0d, errors: %0d", checked_stores, errors);
  endtask

  task automatic begin_program();
    int i;
    @(posedge CLOCK);
    reset <= 1'b1;
    reset_model();
    for (i = 0; i < 32; i++) begin
      data_mem[i] = word_t'(i * 5);
    end
    store_count = 0;
    load_count  = 0;
    hold_count  = 0;
  endtask

  task automatic wait_for_stores(input int limit);
    int cycles;
    cycles = 0;
    while (store_count < expected_stores) begin
      @(posedge CLOCK);
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: only %0d of %0d stores seen within %0d cycles",
                 store_count, expected_stores, limit);
        errors++;
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  endtask

  // A negative hold count skips the PC hold check
  task automatic run_program(input int expected_holds, input int limit);
    repeat (RESET_CYCLES) @(posedge CLOCK);
    reset <= 1'b0;
    wait_for_stores(limit);
    repeat (8) @(posedge CLOCK);  // Drain to catch extra stores
    if (expected_holds >= 0) begin
      a_hold_count: assert (hold_count == expected_holds)
        else begin
          errors++;
          $display("FAILED at %0t: PC held %0d times, expected %0d", $time,
                   hold_count, expected_holds);
        end
    end
    a_load_count: assert (load_count == expected_loads)
      else begin
        errors++;
        $display("FAILED at %0t: %0d loads seen, expected %0d", $time,
                 load_count, expected_loads);
      end
    checked_stores += store_count;
  endtask

  task automatic build_random_program(input int count);
    int         n;
    int         pick;
    reg_index_t a;
    reg_index_t b;
    reg_index_t c;
    logic [8:0] offset;
    for (n = 0; n < count; n++) begin
      pick   = int'(next_random() % 6);
      a      = reg_index_t'(next_random() % 32);
      b      = reg_index_t'(next_random() % 32);
      c      = reg_index_t'(next_random() % 32);
      offset = 9'(next_random() % 25);
      case (pick)
        0:       load_instr(a, b, offset);
        1:       store_instr(a, b, offset);
        2:       alu_instr(OPCODE_ADD, a, b, c);
        3:       alu_instr(OPCODE_SUB, a, b, c);
        4:       alu_instr(OPCODE_AND, a, b, c);
        default: alu_instr(OPCODE_ORR, a, b, c);
      endcase
    end
  endtask

  initial begin
    reset = 1'b1;

    begin_program();  // Dependent ALU chain
    alu_instr(OPCODE_ADD, 9, 1, 2);
    store_instr(9, 0, 0);
    alu_instr(OPCODE_SUB, 10, 9, 4);
    store_instr(10, 1, 1);
    alu_instr(OPCODE_AND, 11, 10, 7);
    store_instr(11, 2, 2);
    alu_instr(OPCODE_ORR, 12, 11, 20);
    store_instr(12, 3, 3);
    alu_instr(OPCODE_ADD, 13, 12, 10);
    alu_instr(OPCODE_ADD, 14, 5, 6);
    store_instr(13, 14, 4);  // X13 comes from writeback
    run_program(0, 100);

    begin_program();  // Load-use
    load_instr(5, 2, 4);
    alu_instr(OPCODE_ADD, 6, 5, 1);
    store_instr(6, 0, 16);
    run_program(1, 100);

    begin_program();  // XZR
    alu_instr(OPCODE_ADD, ZERO_REG, 1, 2);
    store_instr(ZERO_REG, 5, 0);
    store_instr(3, ZERO_REG, 12);
    load_instr(ZERO_REG, 0, 0);
    alu_instr(OPCODE_ADD, 8, ZERO_REG, ZERO_REG);
    store_instr(8, 0, 1);
    run_program(0, 100);

    begin_program();
    build_random_program(200);
    run_program(-1, 1000);

    report_counts();
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
